/* common/lc4_settings.svh */
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

// Datapath and address width of the LC4 machine
`define LC4_WORD_W   16

// Register index width, three bits select one of eight registers
`define LC4_REG_W    3

// Size of the register file
`define LC4_NUM_REGS 8

// First fetch address after reset, start of user code space
`define LC4_RESET_PC 16'h8200

`endif

/* common/lc4_pkg.sv */
`include "lc4_settings.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0] lc4_word_t; // Data word and address
    typedef logic [`LC4_REG_W-1:0]  lc4_reg_t;  // Register index

    // Primary opcode, bits [15:12] of the instruction
    typedef enum logic [3:0] {
        OP_ARITH   = 4'b0001, // ADD, MUL, SUB, ADD immediate
        OP_LOGIC   = 4'b0101, // AND, NOT, OR, XOR, AND immediate
        OP_LDR     = 4'b0110,
        OP_STR     = 4'b0111,
        OP_CONST   = 4'b1001, // Signed 9-bit constant
        OP_SHIFT   = 4'b1010, // SLL, SRA, SRL
        OP_HICONST = 4'b1101  // Upper byte insert
    } lc4_opcode_e;

    // Operation selected by the decoder for the execute stage
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_MUL,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_SLL,
        ALU_SRA,
        ALU_SRL,
        ALU_CONST,
        ALU_HICONST,
        ALU_ADDR      // Base plus 6-bit offset for LDR and STR
    } lc4_alu_op_e;

endpackage

/* design/lc4_fetch.sv */
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_fetch import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  lc4_word_t i_insn,    // Combinational read of imem at o_pc
    output lc4_word_t o_pc,
    output lc4_word_t o_d_pc,    // Fetch/decode register
    output lc4_word_t o_d_insn,
    output logic      o_d_valid
);

    // No branches, so the PC only ever counts up
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_pc      <= `LC4_RESET_PC;
            o_d_valid <= 1'b0;           // Bubble until the first real fetch
        end else begin
            o_pc      <= o_pc + 16'd1;
            o_d_valid <= 1'b1;
        end
    end

    // Payload of the fetch/decode register
    always_ff @(posedge gwe) begin
        o_d_pc   <= o_pc;
        o_d_insn <= i_insn;
    end

endmodule

/* decode/lc4_decoder.sv */
`timescale 1ns/1ps

module lc4_decoder import lc4_pkg::*; (
    input  lc4_word_t   i_insn,
    output lc4_reg_t    o_rs,          // First source
    output lc4_reg_t    o_rt,          // Second source, store data for STR
    output lc4_reg_t    o_rd,
    output logic        o_regfile_we,
    output logic        o_is_load,
    output logic        o_is_store,
    output lc4_alu_op_e o_alu_op
);

    lc4_opcode_e opcode;

    assign opcode = lc4_opcode_e'(i_insn[15:12]);

    always_comb begin
        // Common field positions, overridden per opcode below
        o_rd         = i_insn[11:9];
        o_rs         = i_insn[8:6];
        o_rt         = i_insn[2:0];
        o_regfile_we = 1'b0;
        o_is_load    = 1'b0;
        o_is_store   = 1'b0;
        o_alu_op     = ALU_ADD;       // Don't care when nothing is written
        case (opcode)
            OP_ARITH: begin
                o_regfile_we = 1'b1;
                if (!i_insn[5]) begin // Register form, sub-op in [4:3]
                    case (i_insn[4:3])
                        2'b00:   o_alu_op = ALU_ADD;
                        2'b01:   o_alu_op = ALU_MUL;
                        2'b10:   o_alu_op = ALU_SUB;
                        default: o_regfile_we = 1'b0; // DIV not built
                    endcase
                end
            end
            OP_LOGIC: begin
                o_regfile_we = 1'b1;
                o_alu_op     = ALU_AND;  // AND immediate when bit 5 set
                if (!i_insn[5]) begin
                    case (i_insn[4:3])
                        2'b00:   o_alu_op = ALU_AND;
                        2'b01:   o_alu_op = ALU_NOT;
                        2'b10:   o_alu_op = ALU_OR;
                        default: o_alu_op = ALU_XOR;
                    endcase
                end
            end
            OP_LDR: begin
                o_regfile_we = 1'b1;
                o_is_load    = 1'b1;
                o_alu_op     = ALU_ADDR;
            end
            OP_STR: begin
                o_rt       = i_insn[11:9]; // Data register sits in the rd slot
                o_is_store = 1'b1;
                o_alu_op   = ALU_ADDR;
            end
            OP_CONST: begin
                o_regfile_we = 1'b1;
                o_alu_op     = ALU_CONST;
            end
            OP_SHIFT: begin
                o_regfile_we = 1'b1;
                case (i_insn[5:4])
                    2'b00:   o_alu_op = ALU_SLL;
                    2'b01:   o_alu_op = ALU_SRA;
                    2'b10:   o_alu_op = ALU_SRL;
                    default: o_regfile_we = 1'b0; // MOD not built
                endcase
            end
            OP_HICONST: begin
                o_rs         = i_insn[11:9]; // Reads its own destination
                o_regfile_we = 1'b1;
                o_alu_op     = ALU_HICONST;
            end
            default: ; // Unsupported, flows through as a no-op
        endcase
    end

endmodule

/* decode/lc4_regfile.sv */
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_regfile import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  lc4_reg_t  i_rs,
    input  lc4_reg_t  i_rt,
    input  lc4_reg_t  i_rd,       // Write port, driven from writeback
    input  logic      i_rd_we,
    input  lc4_word_t i_wdata,
    output lc4_word_t o_rs_data,
    output lc4_word_t o_rt_data
);

    lc4_word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Write-through, a read of the register being written sees the new value
    assign o_rs_data = (i_rd_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rd_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

/* execute/lc4_alu.sv */
`timescale 1ns/1ps

module lc4_alu import lc4_pkg::*; (
    input  lc4_alu_op_e i_alu_op,
    input  lc4_word_t   i_insn,     // Source of immediates
    input  lc4_word_t   i_rs_data,  // Forwarded operands
    input  lc4_word_t   i_rt_data,
    output lc4_word_t   o_result
);

    lc4_opcode_e opcode;
    logic        use_imm5;
    lc4_word_t   imm5_sext;
    lc4_word_t   imm6_sext;
    lc4_word_t   imm9_sext;
    lc4_word_t   operand_b;
    logic [3:0]  shamt;

    assign opcode    = lc4_opcode_e'(i_insn[15:12]);
    assign imm5_sext = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6_sext = {{10{i_insn[5]}}, i_insn[5:0]};  // LDR/STR offset
    assign imm9_sext = {{7{i_insn[8]}}, i_insn[8:0]};   // CONST
    assign shamt     = i_insn[3:0];

    // ADD and AND have an immediate form flagged by bit 5
    assign use_imm5  = i_insn[5] && ((opcode == OP_ARITH) || (opcode == OP_LOGIC));
    assign operand_b = use_imm5 ? imm5_sext : i_rt_data;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:     o_result = i_rs_data + operand_b;
            ALU_MUL:     o_result = i_rs_data * i_rt_data; // Low 16 bits kept
            ALU_SUB:     o_result = i_rs_data - i_rt_data;
            ALU_AND:     o_result = i_rs_data & operand_b;
            ALU_OR:      o_result = i_rs_data | i_rt_data;
            ALU_XOR:     o_result = i_rs_data ^ i_rt_data;
            ALU_NOT:     o_result = ~i_rs_data;
            ALU_SLL:     o_result = i_rs_data << shamt;
            ALU_SRA:     o_result = $signed(i_rs_data) >>> shamt; // Sign fill
            ALU_SRL:     o_result = i_rs_data >> shamt;
            ALU_CONST:   o_result = imm9_sext;
            // Upper byte from the instruction, lower byte kept from rd
            ALU_HICONST: o_result = {i_insn[7:0], i_rs_data[7:0]};
            ALU_ADDR:    o_result = i_rs_data + imm6_sext;
            default:     o_result = '0;
        endcase
    end

endmodule

/* execute/lc4_execute_stage.sv */
`timescale 1ns/1ps

module lc4_execute_stage import lc4_pkg::*; (
    input  logic        gwe,
    input  logic        i_rst,
    input  logic        i_d_valid,
    input  lc4_word_t   i_d_pc,
    input  lc4_word_t   i_d_insn,
    input  lc4_reg_t    i_rs,
    input  lc4_reg_t    i_rt,
    input  lc4_reg_t    i_rd,
    input  lc4_word_t   i_rs_data,
    input  lc4_word_t   i_rt_data,
    input  logic        i_regfile_we,
    input  logic        i_is_load,
    input  logic        i_is_store,
    input  lc4_alu_op_e i_alu_op,
    input  lc4_reg_t    i_w_rd,       // Writeback feedback
    input  logic        i_w_we,
    input  lc4_word_t   i_w_data,
    output logic        o_m_valid,
    output lc4_word_t   o_m_pc,
    output lc4_word_t   o_m_insn,
    output lc4_reg_t    o_m_rd,
    output lc4_reg_t    o_m_rt,
    output logic        o_m_we,
    output logic        o_m_is_load,
    output logic        o_m_is_store,
    output lc4_word_t   o_m_result,
    output lc4_word_t   o_m_rt_data   // Store data, may still be fixed up in memory
);

    logic        x_valid, x_we, x_is_load, x_is_store;
    lc4_word_t   x_pc, x_insn, x_rs_data, x_rt_data;
    lc4_reg_t    x_rs, x_rt, x_rd;
    lc4_alu_op_e x_alu_op;
    lc4_word_t   rs_fwd, rt_fwd, alu_result;
    logic        m_fwd_ok;

    // Decode/execute control, write and memory flags folded with valid here
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            x_valid    <= 1'b0;
            x_we       <= 1'b0;
            x_is_load  <= 1'b0;
            x_is_store <= 1'b0;
        end else begin
            x_valid    <= i_d_valid;
            x_we       <= i_d_valid & i_regfile_we;
            x_is_load  <= i_d_valid & i_is_load;
            x_is_store <= i_d_valid & i_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc      <= i_d_pc;
        x_insn    <= i_d_insn;
        x_rs      <= i_rs;
        x_rt      <= i_rt;
        x_rd      <= i_rd;
        x_rs_data <= i_rs_data;
        x_rt_data <= i_rt_data;
        x_alu_op  <= i_alu_op;
    end

    // A load in memory has no data yet, only its writeback copy counts
    assign m_fwd_ok = o_m_we && !o_m_is_load;

    // Youngest producer first, MX then WX, else the value read in decode
    function automatic lc4_word_t fwd_sel(lc4_reg_t sel, lc4_word_t stale);
        if (m_fwd_ok && (o_m_rd == sel))
            return o_m_result;
        else if (i_w_we && (i_w_rd == sel))
            return i_w_data;
        return stale;
    endfunction

    assign rs_fwd = fwd_sel(x_rs, x_rs_data);
    assign rt_fwd = fwd_sel(x_rt, x_rt_data);

    lc4_alu u_alu (
        .i_alu_op(x_alu_op), .i_insn(x_insn),
        .i_rs_data(rs_fwd), .i_rt_data(rt_fwd), .o_result(alu_result)
    );

    // Execute/memory register
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_m_valid    <= 1'b0;
            o_m_we       <= 1'b0;
            o_m_is_load  <= 1'b0;
            o_m_is_store <= 1'b0;
        end else begin
            o_m_valid    <= x_valid;
            o_m_we       <= x_we;
            o_m_is_load  <= x_is_load;
            o_m_is_store <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        o_m_pc      <= x_pc;
        o_m_insn    <= x_insn;
        o_m_rd      <= x_rd;
        o_m_rt      <= x_rt;     // Kept for WM store-data bypass
        o_m_result  <= alu_result;
        o_m_rt_data <= rt_fwd;
    end

endmodule

/* design/lc4_mem_wb.sv */
`timescale 1ns/1ps

module lc4_mem_wb import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  logic      i_m_valid,
    input  lc4_word_t i_m_pc,
    input  lc4_word_t i_m_insn,
    input  lc4_reg_t  i_m_rd,
    input  lc4_reg_t  i_m_rt,
    input  logic      i_m_we,
    input  logic      i_m_is_load,
    input  logic      i_m_is_store,
    input  lc4_word_t i_m_result,    // ALU value, or address for LDR/STR
    input  lc4_word_t i_m_rt_data,
    input  lc4_word_t i_dmem_rdata,
    output lc4_word_t o_dmem_addr,
    output logic      o_dmem_we,
    output lc4_word_t o_dmem_wdata,
    output logic      o_wb_valid,
    output lc4_word_t o_wb_pc,
    output lc4_word_t o_wb_insn,
    output logic      o_wb_we,
    output lc4_reg_t  o_wb_rd,
    output lc4_word_t o_wb_data       // Trace and register file write data
);

    logic      w_is_load;
    lc4_word_t w_result, w_rdata;

    // Address bus idles at zero when no memory access
    assign o_dmem_addr  = (i_m_is_load || i_m_is_store) ? i_m_result : '0;
    assign o_dmem_we    = i_m_is_store;  // Already qualified by valid upstream
    // WM bypass covers a store right behind a load of its data register
    assign o_dmem_wdata = (o_wb_we && (o_wb_rd == i_m_rt)) ? o_wb_data : i_m_rt_data;

    // Memory/writeback register
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
            o_wb_we    <= 1'b0;
            w_is_load  <= 1'b0;
        end else begin
            o_wb_valid <= i_m_valid;
            o_wb_we    <= i_m_we;
            w_is_load  <= i_m_is_load;
        end
    end

    always_ff @(posedge gwe) begin
        o_wb_pc   <= i_m_pc;
        o_wb_insn <= i_m_insn;
        o_wb_rd   <= i_m_rd;
        w_result  <= i_m_result;
        w_rdata   <= i_dmem_rdata; // Captured on every edge, used for loads
    end

    assign o_wb_data = w_is_load ? w_rdata : w_result;

endmodule

/* design/lc4_pipe_top.sv */
`timescale 1ns/1ps

module lc4_pipe_top import lc4_pkg::*; (
    input  logic      gwe,          // Core clock
    input  logic      i_rst,        // Synchronous reset
    output lc4_word_t o_pc,         // Instruction memory address
    input  lc4_word_t i_insn,       // Instruction memory data, same cycle
    output lc4_word_t o_dmem_addr,
    output logic      o_dmem_we,
    output lc4_word_t o_dmem_wdata,
    input  lc4_word_t i_dmem_rdata, // Data memory read, same cycle
    output logic      o_wb_valid,   // Writeback trace
    output lc4_word_t o_wb_pc,
    output lc4_word_t o_wb_insn,
    output logic      o_wb_we,
    output lc4_reg_t  o_wb_rd,
    output lc4_word_t o_wb_data
);

    // Decode stage
    lc4_word_t   d_pc, d_insn;
    logic        d_valid;
    lc4_reg_t    d_rs, d_rt, d_rd;
    logic        d_regfile_we, d_is_load, d_is_store;
    lc4_alu_op_e d_alu_op;
    lc4_word_t   d_rs_data, d_rt_data;

    // Memory stage
    logic        m_valid, m_we, m_is_load, m_is_store;
    lc4_word_t   m_pc, m_insn, m_result, m_rt_data;
    lc4_reg_t    m_rd, m_rt;

    lc4_fetch u_fetch (
        .gwe(gwe), .i_rst(i_rst), .i_insn(i_insn),
        .o_pc(o_pc), .o_d_pc(d_pc), .o_d_insn(d_insn), .o_d_valid(d_valid)
    );

    lc4_decoder u_decoder (
        .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
        .o_regfile_we(d_regfile_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
        .o_alu_op(d_alu_op)
    );

    // Written from writeback, read in decode with write-through
    lc4_regfile u_regfile (
        .gwe(gwe), .i_rst(i_rst), .i_rs(d_rs), .i_rt(d_rt),
        .i_rd(o_wb_rd), .i_rd_we(o_wb_we), .i_wdata(o_wb_data),
        .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
    );

    lc4_execute_stage u_execute (
        .gwe(gwe), .i_rst(i_rst),
        .i_d_valid(d_valid), .i_d_pc(d_pc), .i_d_insn(d_insn),
        .i_rs(d_rs), .i_rt(d_rt), .i_rd(d_rd), .i_rs_data(d_rs_data), .i_rt_data(d_rt_data),
        .i_regfile_we(d_regfile_we), .i_is_load(d_is_load), .i_is_store(d_is_store),
        .i_alu_op(d_alu_op),
        .i_w_rd(o_wb_rd), .i_w_we(o_wb_we), .i_w_data(o_wb_data), // WX bypass
        .o_m_valid(m_valid), .o_m_pc(m_pc), .o_m_insn(m_insn), .o_m_rd(m_rd), .o_m_rt(m_rt),
        .o_m_we(m_we), .o_m_is_load(m_is_load), .o_m_is_store(m_is_store),
        .o_m_result(m_result), .o_m_rt_data(m_rt_data)
    );

    lc4_mem_wb u_mem_wb (
        .gwe(gwe), .i_rst(i_rst),
        .i_m_valid(m_valid), .i_m_pc(m_pc), .i_m_insn(m_insn), .i_m_rd(m_rd), .i_m_rt(m_rt),
        .i_m_we(m_we), .i_m_is_load(m_is_load), .i_m_is_store(m_is_store),
        .i_m_result(m_result), .i_m_rt_data(m_rt_data), .i_dmem_rdata(i_dmem_rdata),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
        .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
        .o_wb_we(o_wb_we), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

endmodule

/* bench/lc4_tb_program.svh */
`ifndef LC4_TB_PROGRAM_SVH
`define LC4_TB_PROGRAM_SVH

// One row per instruction, fetched in order from the reset PC
// Columns: name, instruction, rd write enable, rd, writeback data,
// store flag, store address, store data
localparam int PROG_LEN = 26;

task automatic build_program();
    // Constants, HICONST reads its own rd one slot after CONST (MX)
    add_row("const_r1",    16'h93FE, 1'b1, 3'd1, 16'hFFFE, 1'b0, 16'h0000, 16'h0000);
    add_row("hiconst_r1",  16'hD312, 1'b1, 3'd1, 16'h12FE, 1'b0, 16'h0000, 16'h0000);
    add_row("const_r2",    16'h94A5, 1'b1, 3'd2, 16'h00A5, 1'b0, 16'h0000, 16'h0000);
    add_row("hiconst_r2",  16'hD580, 1'b1, 3'd2, 16'h80A5, 1'b0, 16'h0000, 16'h0000);
    add_row("const_r3",    16'h9607, 1'b1, 3'd3, 16'h0007, 1'b0, 16'h0000, 16'h0000);
    // Arithmetic, R3 one, two, three slots back
    add_row("add_r4",      16'h1843, 1'b1, 3'd4, 16'h1305, 1'b0, 16'h0000, 16'h0000);
    add_row("mul_r5",      16'h1ACB, 1'b1, 3'd5, 16'h0031, 1'b0, 16'h0000, 16'h0000);
    add_row("sub_r6",      16'h1CD1, 1'b1, 3'd6, 16'hED09, 1'b0, 16'h0000, 16'h0000);
    add_row("addi_r7",     16'h1EBD, 1'b1, 3'd7, 16'h80A2, 1'b0, 16'h0000, 16'h0000);
    // Logic group
    add_row("and_r4",      16'h5842, 1'b1, 3'd4, 16'h00A4, 1'b0, 16'h0000, 16'h0000);
    add_row("not_r5",      16'h5A88, 1'b1, 3'd5, 16'h7F5A, 1'b0, 16'h0000, 16'h0000);
    add_row("or_r6",       16'h5C53, 1'b1, 3'd6, 16'h12FF, 1'b0, 16'h0000, 16'h0000);
    add_row("xor_r7",      16'h5E5A, 1'b1, 3'd7, 16'h925B, 1'b0, 16'h0000, 16'h0000);
    add_row("andi_r4",     16'h58AF, 1'b1, 3'd4, 16'h0005, 1'b0, 16'h0000, 16'h0000);
    // Shifts by four, SRA fills with the sign of 80A5
    add_row("sll_r5",      16'hAAC4, 1'b1, 3'd5, 16'h0070, 1'b0, 16'h0000, 16'h0000);
    add_row("sra_r6",      16'hAC94, 1'b1, 3'd6, 16'hF80A, 1'b0, 16'h0000, 16'h0000);
    add_row("srl_r7",      16'hAEA4, 1'b1, 3'd7, 16'h080A, 1'b0, 16'h0000, 16'h0000);
    // Dependent chain
    add_row("addi_r1",     16'h12E5, 1'b1, 3'd1, 16'h000C, 1'b0, 16'h0000, 16'h0000);
    add_row("add_r2_mx",   16'h1441, 1'b1, 3'd2, 16'h0018, 1'b0, 16'h0000, 16'h0000);
    add_row("sub_r3_wx",   16'h1691, 1'b1, 3'd3, 16'h000C, 1'b0, 16'h0000, 16'h0000);
    // Store of the value just made, then load it back
    add_row("str_r3",      16'h7703, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0008, 16'h000C);
    add_row("ldr_r5",      16'h6B03, 1'b1, 3'd5, 16'h000C, 1'b0, 16'h0000, 16'h0000);
    add_row("const_r6",    16'h9C01, 1'b1, 3'd6, 16'h0001, 1'b0, 16'h0000, 16'h0000);
    add_row("add_r7_load", 16'h1F43, 1'b1, 3'd7, 16'h0018, 1'b0, 16'h0000, 16'h0000);
    add_row("str_r7",      16'h7F3F, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0004, 16'h0018);
    add_row("ldr_r1",      16'h633F, 1'b1, 3'd1, 16'h0018, 1'b0, 16'h0000, 16'h0000);
endtask

`endif

/* bench/lc4_pipe_tb.sv */
`timescale 1ns/1ps
`include "lc4_settings.svh"

module lc4_pipe_tb import lc4_pkg::*; ();

    `include "lc4_tb_program.svh"

    localparam int        CLK_PERIOD   = 4;
    localparam int        RESET_CYCLES = 16;
    localparam int        DMEM_WORDS   = 64;
    localparam lc4_word_t NOP_INSN     = 16'h0000;  // Opcode 0000, no-op in this core

    logic      gwe   = 1'b0;
    logic      i_rst = 1'b1;    // Held from time zero
    lc4_word_t o_pc, i_insn, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    logic      o_dmem_we, o_wb_valid, o_wb_we;
    lc4_word_t o_wb_pc, o_wb_insn, o_wb_data;
    lc4_reg_t  o_wb_rd;

    // Program table
    string     row_name     [PROG_LEN];
    lc4_word_t row_insn     [PROG_LEN];
    logic      row_we       [PROG_LEN];
    lc4_reg_t  row_rd       [PROG_LEN];
    lc4_word_t row_data     [PROG_LEN];
    logic      row_is_store [PROG_LEN];
    lc4_word_t row_st_addr  [PROG_LEN];
    lc4_word_t row_st_data  [PROG_LEN];
    int        row_count = 0;

    lc4_word_t dmem [DMEM_WORDS];
    lc4_word_t imem_index;
    lc4_word_t store_addr_q[$];  // Stores seen on the data memory port
    lc4_word_t store_data_q[$];

    lc4_pipe_top UUT (
        .gwe(gwe), .i_rst(i_rst), .o_pc(o_pc), .i_insn(i_insn),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
        .i_dmem_rdata(i_dmem_rdata),
        .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
        .o_wb_we(o_wb_we), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

    always #(CLK_PERIOD / 2) gwe = ~gwe;

    // Instruction memory, combinational, NOPs past the end of the table
    assign imem_index = o_pc - `LC4_RESET_PC;
    assign i_insn     = (imem_index < PROG_LEN) ? row_insn[imem_index[4:0]] : NOP_INSN;

    // Data memory, combinational read and write at the edge
    assign i_dmem_rdata = dmem[o_dmem_addr[5:0]];
    always @(posedge gwe) begin
        if (o_dmem_we === 1'b1) dmem[o_dmem_addr[5:0]] <= o_dmem_wdata;
    end

    // Store monitor, sampled mid-cycle where the ports are settled
    always @(negedge gwe) begin
        if (o_dmem_we === 1'b1) begin
            store_addr_q.push_back(o_dmem_addr);
            store_data_q.push_back(o_dmem_wdata);
        end
    end

    task automatic add_row(input string name, input lc4_word_t insn, input logic we,
                           input lc4_reg_t rd, input lc4_word_t data, input logic is_store,
                           input lc4_word_t st_addr, input lc4_word_t st_data);
        row_name[row_count]     = name;
        row_insn[row_count]     = insn;
        row_we[row_count]       = we;
        row_rd[row_count]       = rd;
        row_data[row_count]     = data;
        row_is_store[row_count] = is_store;
        row_st_addr[row_count]  = st_addr;
        row_st_data[row_count]  = st_data;
        row_count++;
    endtask

    task automatic compare_value(input string name, input lc4_word_t expected,
                                 input lc4_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Watchdog, reset plus one slot per row plus pipeline drain
    initial begin
        #((RESET_CYCLES + PROG_LEN + 10) * CLK_PERIOD);
        $display("Timeout: the expected writebacks did not all arrive in time");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 16'hD000 + 16'(i);   // Distinct from every stored value
        end
        build_program();
        // Reset window, PC parked and nothing leaves the pipe
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(posedge gwe);
            if (cyc == RESET_CYCLES - 1) i_rst <= 1'b0;
            @(negedge gwe);
            compare_value("reset pc", `LC4_RESET_PC, o_pc);
            compare_value("reset wb_valid", 16'd0, {15'd0, o_wb_valid});
            compare_value("reset dmem_we", 16'd0, {15'd0, o_dmem_we});
        end
        // Row k is the k-th valid writeback
        for (int k = 0; k < PROG_LEN; k++) begin
            @(negedge gwe);
            while (o_wb_valid !== 1'b1) @(negedge gwe);
            compare_value($sformatf("%s pc", row_name[k]), `LC4_RESET_PC + 16'(k), o_wb_pc);
            compare_value($sformatf("%s insn", row_name[k]), row_insn[k], o_wb_insn);
            compare_value($sformatf("%s we", row_name[k]), {15'd0, row_we[k]},
                          {15'd0, o_wb_we});
            if (row_we[k]) begin
                compare_value($sformatf("%s rd", row_name[k]), {13'd0, row_rd[k]},
                              {13'd0, o_wb_rd});
                compare_value($sformatf("%s data", row_name[k]), row_data[k], o_wb_data);
            end
            if (row_is_store[k]) begin
                if (store_addr_q.size() == 0) begin
                    $display("No data memory write was seen for store %s", row_name[k]);
                    $display("=== FAIL ===");
                    $fatal(1, "Missing store");
                end else begin
                    compare_value($sformatf("%s addr", row_name[k]), row_st_addr[k],
                                  store_addr_q.pop_front());
                    compare_value($sformatf("%s wdata", row_name[k]), row_st_data[k],
                                  store_data_q.pop_front());
                end
            end
        end
        compare_value("extra stores", 16'd0, 16'(store_addr_q.size()));
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* lc4_pipe.f */
+incdir+common
+incdir+bench
common/lc4_pkg.sv
design/lc4_fetch.sv
decode/lc4_decoder.sv
decode/lc4_regfile.sv
execute/lc4_alu.sv
execute/lc4_execute_stage.sv
design/lc4_mem_wb.sv
design/lc4_pipe_top.sv
bench/lc4_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module lc4_pipe_tb -f lc4_pipe.f \
    -o lc4_pipe_sim \
    && ./obj_dir/lc4_pipe_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -qx "=== PASS ===" sim.log \
    && { echo "Result: pass"; exit 0; } \
    || { echo "Result: fail"; exit 1; }
